// File: tb.f
+incdir+verilog
+incdir+bench
verilog/riscv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/imm_gen.sv
verilog/instr_classifier.sv
verilog/decode_stage.sv
bench/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/riscv_isa_pkg.sv
      - verilog/decode_pkg.sv
      - verilog/imm_gen.sv
      - verilog/instr_classifier.sv
      - verilog/decode_stage.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_decode_stage.sv

// File: bench/decode_ref_model.svh
//**************************************************************************
// expected decode from the RV64IM encoding rules; include after the imports
// illegal encodings define only the exception, their control fields are free
//**************************************************************************

`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// the signed temporaries carry the sign into the 64-bit result
function automatic xlen_t format_immediate(input instr_t w);
    logic signed [31:0] u_imm;
    logic signed [20:0] j_imm;
    logic signed [12:0] b_imm;
    logic signed [11:0] s_imm;
    logic signed [11:0] i_imm;
    xlen_t              imm;
    u_imm = {w[31:12], 12'h000};
    j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    s_imm = {w[31:25], w[11:7]};
    i_imm = w[31:20];
    case (w[6:0])
        OP_LUI, OP_AUIPC: imm = xlen_t'(u_imm);
        OP_JAL:           imm = xlen_t'(j_imm);
        OP_BRANCH:        imm = xlen_t'(b_imm);
        OP_STORE:         imm = xlen_t'(s_imm);
        default:          imm = xlen_t'(i_imm);
    endcase
    return imm;
endfunction

function automatic decode_ctrl_t classify_instr(input instr_t w);
    instr_type_e  load_ops[8]   = '{LB, LH, LW, LD, LBU, LHU, LWU, LB};
    instr_type_e  store_ops[4]  = '{SB, SH, SW, SD};
    instr_type_e  branch_ops[8] = '{BEQ, BNE, BEQ, BEQ, BLT, BGE, BLTU, BGEU};
    instr_type_e  alu_ops[8]    = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    instr_type_e  md_ops[8]     = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    instr_type_e  md_w_ops[8]   = '{MULW, MULW, MULW, MULW, DIVW, DIVUW, REMW, REMUW};
    decode_ctrl_t c;
    logic [2:0]   f3;
    logic [6:0]   f7;
    f3 = w[14:12];
    f7 = w[31:25];
    c = '0;
    c.funct3 = f3;
    case (w[6:0])
        OP_LUI: begin
            c.instr_type = OR;
            c.regfile_we = 1'b1;
            c.use_imm    = 1'b1;
        end
        OP_AUIPC: begin
            c.instr_type = ADD;
            c.regfile_we = 1'b1;
            c.use_imm    = 1'b1;
            c.use_pc     = 1'b1;
        end
        OP_JAL, OP_JALR: begin
            c.instr_type = (w[6:0] == OP_JAL) ? JAL : JALR;
            c.unit       = UNIT_BRANCH;
            c.wb_sel     = FROM_BRANCH;
            c.regfile_we = 1'b1;
            c.use_imm    = 1'b1;
            c.use_pc     = 1'b1;
            c.illegal    = (w[6:0] == OP_JALR) && (f3 != 3'd0);
        end
        OP_BRANCH: begin
            c.instr_type = branch_ops[f3];
            c.unit       = UNIT_BRANCH;
            c.wb_sel     = FROM_BRANCH;
            c.use_imm    = 1'b1;
            c.use_pc     = 1'b1;
            c.illegal    = (f3[2:1] == 2'b01);
        end
        OP_LOAD, OP_STORE: begin
            c.unit    = UNIT_MEM;
            c.wb_sel  = FROM_MEM;
            c.use_imm = 1'b1;
            if (w[6:0] == OP_LOAD) begin
                c.instr_type = load_ops[f3];
                c.regfile_we = 1'b1;
                c.illegal    = (f3 == 3'd7);
            end else begin
                c.instr_type = store_ops[f3[1:0]];
                c.mem_op     = MEM_STORE;
                c.illegal    = f3[2];
            end
        end
        OP_ALU_I: begin
            c.instr_type = alu_ops[f3];
            c.regfile_we = 1'b1;
            c.use_imm    = 1'b1;
            // shamt[5] sits in funct7 bit 0
            if (f3 == 3'd5 && f7[6:1] == 6'b010000) begin
                c.instr_type = SRA;
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                c.illegal = (f7[6:1] != 6'd0);
            end
        end
        OP_ALU_I_W: begin
            c.regfile_we = 1'b1;
            c.use_imm    = 1'b1;
            c.op_32      = 1'b1;
            c.instr_type = (f3 == 3'd1) ? SLLW : (f3 != 3'd5) ? ADDW :
                           (f7 == 7'h20) ? SRAW : SRLW;
            c.illegal    = !(f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00) ||
                             (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20)));
        end
        OP_ALU, OP_ALU_W: begin
            c.regfile_we = 1'b1;
            c.op_32      = (w[6:0] == OP_ALU_W);
            if (f7 == 7'h01) begin
                c.instr_type = c.op_32 ? md_w_ops[f3] : md_ops[f3];
                c.unit       = (c.instr_type inside {DIV, DIVU, REM, REMU,
                                                     DIVW, DIVUW, REMW, REMUW}) ?
                               UNIT_DIV : UNIT_MUL;
                c.signed_op  = (f3 == 3'd4 || f3 == 3'd6);
                c.illegal    = c.op_32 && (f3 inside {3'd1, 3'd2, 3'd3});
            end else if (f7 == 7'h00) begin
                c.instr_type = alu_ops[f3];
                if (c.op_32) begin
                    c.instr_type = (f3 == 3'd0) ? ADDW : (f3 == 3'd1) ? SLLW : SRLW;
                    c.illegal    = !(f3 inside {3'd0, 3'd1, 3'd5});
                end
            end else if (f7 == 7'h20) begin
                c.instr_type = c.op_32 ? ((f3 == 3'd0) ? SUBW : SRAW) :
                                         ((f3 == 3'd0) ? SUB : SRA);
                c.illegal    = !(f3 inside {3'd0, 3'd5});
            end else begin
                c.illegal = 1'b1;
            end
        end
        // atomics, fence, system and unknown opcodes
        default: c.illegal = 1'b1;
    endcase
    return c;
endfunction

function automatic decoded_instr_t expected_decode(input instr_t w, input xlen_t pc);
    decoded_instr_t d;
    logic           misaligned;
    d.pc        = pc;
    d.rs1       = (w[6:0] == OP_LUI) ? 5'd0 : w[19:15];
    d.rs2       = w[24:20];
    d.rd        = w[11:7];
    d.imm       = format_immediate(w);
    d.ctrl      = classify_instr(w);
    misaligned  = (w[6:0] == OP_JAL) && d.imm[1];
    d.ex.valid  = misaligned || d.ctrl.illegal;
    d.ex.cause  = misaligned ? INSTR_ADDR_MISALIGNED : ILLEGAL_INSTR;
    d.ex.origin = pc;
    return d;
endfunction

function automatic jump_req_t expected_jump(input instr_t w, input xlen_t pc);
    jump_req_t j;
    xlen_t     imm;
    imm         = format_immediate(w);
    j.valid     = (w[6:0] == OP_JAL) && !imm[1];
    j.jump_addr = pc + imm;
    return j;
endfunction

`endif

// File: bench/tb_decode_stage.sv
//**************************************************************************
// random RV64IM words against the reference model; stops at the first mismatch
//**************************************************************************

`default_nettype none

module tb_decode_stage;

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    `include "decode_ref_model.svh"

    localparam int NUM_TXN        = 2000;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 2 + RESET_CYCLES;

    typedef struct packed {
        logic           valid;
        decoded_instr_t rec;
        jump_req_t      jump;
    } expect_t;

    logic           clk_i;
    logic           arst_n_i;
    logic           valid_i;
    instr_t         instr_i;
    xlen_t          pc_i;
    logic           decode_valid_o;
    decoded_instr_t decoded_o;
    jump_req_t      jump_o;

    expect_t        pending[$];
    logic [31:0]    rng;
    int             sent;
    int             checked;
    int             error_count;
    int             cycle_count;

    decode_stage i_dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid_i),
        .instr_i        (instr_i),
        .pc_i           (pc_i),
        .decode_valid_o (decode_valid_o),
        .decoded_o      (decoded_o),
        .jump_o         (jump_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a[3:2] == 0 gives a fully random word, else a kept opcode with legal funct7
    function automatic instr_t random_instr(input logic [31:0] a, input logic [31:0] b);
        opcode_e kept_ops[11] = '{OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
                                  OP_STORE, OP_ALU_I, OP_ALU, OP_ALU_I_W, OP_ALU_W};
        funct7_t f7_pick[4]   = '{F7_NORMAL, F7_SUB_SRA, F7_MUL_DIV, b[31:25]};
        instr_t  w;
        funct7_t f7;
        w  = b;
        f7 = f7_pick[a[9:8]];
        if (a[3:2] != 2'b00) begin
            w[6:0] = kept_ops[a[23:16] % 11];
            if (w[6:0] == OP_ALU || w[6:0] == OP_ALU_W || w[6:0] == OP_ALU_I_W) begin
                w[31:25] = f7;
            end else if (w[6:0] == OP_ALU_I) begin
                w[31:26] = f7[6:1];
            end
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_value("decode_valid_o", e.valid, decode_valid_o);
        check_value("jump_o.valid", e.valid && e.jump.valid, jump_o.valid);
        check_value("decoded_o.ex.valid", e.valid && e.rec.ex.valid, decoded_o.ex.valid);
        if (e.valid) begin
            if (e.rec.ex.valid) begin
                check_value("decoded_o.ex.cause", e.rec.ex.cause, decoded_o.ex.cause);
                check_value("decoded_o.ex.origin", e.rec.ex.origin, decoded_o.ex.origin);
            end
            if (e.jump.valid) begin
                check_value("jump_o.jump_addr", e.jump.jump_addr, jump_o.jump_addr);
            end
            check_value("decoded_o.pc", e.rec.pc, decoded_o.pc);
            check_value("decoded_o.rs1", e.rec.rs1, decoded_o.rs1);
            check_value("decoded_o.rs2", e.rec.rs2, decoded_o.rs2);
            check_value("decoded_o.rd", e.rec.rd, decoded_o.rd);
            check_value("decoded_o.imm", e.rec.imm, decoded_o.imm);
            check_value("ctrl.funct3", e.rec.ctrl.funct3, decoded_o.ctrl.funct3);
            check_value("ctrl.illegal", e.rec.ctrl.illegal, decoded_o.ctrl.illegal);
            if (!e.rec.ctrl.illegal) begin
                check_value("ctrl.instr_type", e.rec.ctrl.instr_type,
                            decoded_o.ctrl.instr_type);
                check_value("ctrl.unit", e.rec.ctrl.unit, decoded_o.ctrl.unit);
                check_value("ctrl.wb_sel", e.rec.ctrl.wb_sel, decoded_o.ctrl.wb_sel);
                check_value("ctrl.regfile_we", e.rec.ctrl.regfile_we,
                            decoded_o.ctrl.regfile_we);
                check_value("ctrl.use_imm", e.rec.ctrl.use_imm, decoded_o.ctrl.use_imm);
                check_value("ctrl.use_pc", e.rec.ctrl.use_pc, decoded_o.ctrl.use_pc);
                check_value("ctrl.op_32", e.rec.ctrl.op_32, decoded_o.ctrl.op_32);
                check_value("ctrl.signed_op", e.rec.ctrl.signed_op, decoded_o.ctrl.signed_op);
                check_value("ctrl.mem_op", e.rec.ctrl.mem_op, decoded_o.ctrl.mem_op);
            end
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d of %0d strobes checked",
                 cycle_count, checked, NUM_TXN);
        $display("Result: FAILED");
        $fatal(1, "simulation timed out");
    end

    initial begin
        logic [31:0] r_ctl;
        logic [31:0] r_instr;
        logic [31:0] r_pc_hi;
        logic [31:0] r_pc_lo;
        instr_t      word;
        xlen_t       pc;
        expect_t     entry;
        expect_t     due;
        rng         = 32'h288d;
        sent        = 0;
        checked     = 0;
        error_count = 0;
        arst_n_i    = 1'b0;
        valid_i     = 1'b0;
        instr_i     = '0;
        pc_i        = '0;
        entry       = '0;
        // the first cycle out of reset sees valid_i low
        pending.push_back(entry);
        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;

        while (checked < NUM_TXN) begin
            @(posedge clk_i);
            rng     = xorshift32(rng);
            r_ctl   = rng;
            rng     = xorshift32(rng);
            r_instr = rng;
            rng     = xorshift32(rng);
            r_pc_hi = rng;
            rng     = xorshift32(rng);
            r_pc_lo = rng;
            word    = random_instr(r_ctl, r_instr);
            pc      = {r_pc_hi, r_pc_lo[31:2], 2'b00};
            entry.valid = (r_ctl[1:0] != 2'b00) && (sent < NUM_TXN);
            entry.rec   = expected_decode(word, pc);
            entry.jump  = expected_jump(word, pc);
            valid_i <= entry.valid;
            instr_i <= word;
            pc_i    <= pc;
            pending.push_back(entry);
            if (entry.valid) begin
                sent++;
            end

            @(negedge clk_i);
            due = pending.pop_front();
            compare_outputs(due);
            if (due.valid) begin
                checked++;
            end
        end

        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
//**************************************************************************
// one instruction per valid_i strobe, no back-pressure; record valid 1 cycle later
// record fields other than the valid bits hold their last value while idle
//**************************************************************************

`default_nettype none

module decode_stage (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  valid_i,
    input  wire riscv_isa_pkg::instr_t instr_i,
    input  wire riscv_isa_pkg::xlen_t  pc_i,
    output logic                       decode_valid_o,
    output decode_pkg::decoded_instr_t decoded_o,
    output decode_pkg::jump_req_t      jump_o
);

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    instr_fields_t  fields;
    xlen_t          imm;
    decode_ctrl_t   ctrl;
    logic           is_jal;
    logic           misaligned;
    exception_t     ex_d;
    decoded_instr_t decoded_d;
    decoded_instr_t decoded_q;
    logic           ex_valid_q;
    logic           jump_valid_q;
    xlen_t          jump_addr_q;

    assign fields = instr_fields_t'(instr_i);

    imm_gen i_imm_gen (
        .instr_i (fields),
        .imm_o   (imm)
    );

    instr_classifier i_instr_classifier (
        .instr_i (fields),
        .ctrl_o  (ctrl)
    );

    // JAL target must be 4-byte aligned
    assign is_jal     = (ctrl.instr_type == JAL);
    assign misaligned = is_jal && imm[1];

    always_comb begin
        ex_d.origin = pc_i;
        ex_d.cause  = misaligned ? INSTR_ADDR_MISALIGNED : ILLEGAL_INSTR;
        ex_d.valid  = misaligned || ctrl.illegal;
    end

    always_comb begin
        decoded_d.pc   = pc_i;
        decoded_d.rs1  = (fields.opcode == OP_LUI) ? '0 : fields.rs1;
        decoded_d.rs2  = fields.rs2;
        decoded_d.rd   = fields.rd;
        decoded_d.imm  = imm;
        decoded_d.ctrl = ctrl;
        decoded_d.ex   = ex_d;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            decode_valid_o <= 1'b0;
            ex_valid_q     <= 1'b0;
            jump_valid_q   <= 1'b0;
        end else begin
            decode_valid_o <= valid_i;
            ex_valid_q     <= valid_i && ex_d.valid;
            jump_valid_q   <= valid_i && is_jal && !misaligned;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            decoded_q   <= decoded_d;
            jump_addr_q <= pc_i + imm;
        end
    end

    always_comb begin
        decoded_o          = decoded_q;
        decoded_o.ex.valid = ex_valid_q;
    end

    assign jump_o = '{valid: jump_valid_q, jump_addr: jump_addr_q};

    // a redirect and a trap for the same instruction would race in fetch
    ex_jump_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(decoded_o.ex.valid && jump_o.valid));

    valid_bits_qualified: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (decoded_o.ex.valid || jump_o.valid) |-> decode_valid_o);

endmodule

`default_nettype wire

// File: verilog/instr_classifier.sv
//**************************************************************************
// RV64IM only; atomics, fence, ecall/ebreak and CSR opcodes come out illegal
//**************************************************************************

`default_nettype none

module instr_classifier (
    input  wire riscv_isa_pkg::instr_fields_t instr_i,
    output decode_pkg::decode_ctrl_t          ctrl_o
);

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    always_comb begin
        ctrl_o.instr_type = ADD;
        ctrl_o.unit       = UNIT_ALU;
        ctrl_o.wb_sel     = FROM_ALU;
        ctrl_o.regfile_we = 1'b0;
        ctrl_o.use_imm    = 1'b0;
        ctrl_o.use_pc     = 1'b0;
        ctrl_o.op_32      = 1'b0;
        ctrl_o.signed_op  = 1'b0;
        ctrl_o.mem_op     = MEM_LOAD;
        ctrl_o.funct3     = instr_i.funct3;
        ctrl_o.illegal    = 1'b0;

        case (instr_i.opcode)
            // rs1 is zeroed by the stage, so this is imm | 0
            OP_LUI: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.instr_type = OR;
            end
            OP_AUIPC: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.use_pc     = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.use_pc     = 1'b1;
                ctrl_o.wb_sel     = FROM_BRANCH;
                ctrl_o.unit       = UNIT_BRANCH;
                ctrl_o.instr_type = (instr_i.opcode == OP_JAL) ? JAL : JALR;
                if (instr_i.opcode == OP_JALR && instr_i.funct3 != F3_JALR) begin
                    ctrl_o.illegal = 1'b1;
                end
            end
            OP_BRANCH: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.use_pc  = 1'b1;
                ctrl_o.wb_sel  = FROM_BRANCH;
                ctrl_o.unit    = UNIT_BRANCH;
                case (instr_i.funct3)
                    F3_BEQ:  ctrl_o.instr_type = BEQ;
                    F3_BNE:  ctrl_o.instr_type = BNE;
                    F3_BLT:  ctrl_o.instr_type = BLT;
                    F3_BGE:  ctrl_o.instr_type = BGE;
                    F3_BLTU: ctrl_o.instr_type = BLTU;
                    F3_BGEU: ctrl_o.instr_type = BGEU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OP_LOAD: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.wb_sel     = FROM_MEM;
                ctrl_o.unit       = UNIT_MEM;
                case (instr_i.funct3)
                    F3_LB:   ctrl_o.instr_type = LB;
                    F3_LH:   ctrl_o.instr_type = LH;
                    F3_LW:   ctrl_o.instr_type = LW;
                    F3_LD:   ctrl_o.instr_type = LD;
                    F3_LBU:  ctrl_o.instr_type = LBU;
                    F3_LHU:  ctrl_o.instr_type = LHU;
                    F3_LWU:  ctrl_o.instr_type = LWU;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OP_STORE: begin
                ctrl_o.use_imm = 1'b1;
                ctrl_o.wb_sel  = FROM_MEM;
                ctrl_o.unit    = UNIT_MEM;
                ctrl_o.mem_op  = MEM_STORE;
                case (instr_i.funct3)
                    F3_SB:   ctrl_o.instr_type = SB;
                    F3_SH:   ctrl_o.instr_type = SH;
                    F3_SW:   ctrl_o.instr_type = SW;
                    F3_SD:   ctrl_o.instr_type = SD;
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OP_ALU_I: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                // 6-bit shamt, funct7 bit 0 belongs to it
                case (instr_i.funct3)
                    F3_ADD_SUB: ctrl_o.instr_type = ADD;
                    F3_SLT:     ctrl_o.instr_type = SLT;
                    F3_SLTU:    ctrl_o.instr_type = SLTU;
                    F3_XOR:     ctrl_o.instr_type = XOR;
                    F3_OR:      ctrl_o.instr_type = OR;
                    F3_AND:     ctrl_o.instr_type = AND;
                    F3_SLL: begin
                        ctrl_o.instr_type = SLL;
                        ctrl_o.illegal    = (instr_i.funct7[6:1] != F7_NORMAL[6:1]);
                    end
                    default: begin
                        if (instr_i.funct7[6:1] == F7_SUB_SRA[6:1]) begin
                            ctrl_o.instr_type = SRA;
                        end else if (instr_i.funct7[6:1] == F7_NORMAL[6:1]) begin
                            ctrl_o.instr_type = SRL;
                        end else begin
                            ctrl_o.illegal = 1'b1;
                        end
                    end
                endcase
            end
            OP_ALU_I_W: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.use_imm    = 1'b1;
                ctrl_o.op_32      = 1'b1;
                case ({instr_i.funct7, instr_i.funct3})
                    {F7_NORMAL, F3_SLL}:     ctrl_o.instr_type = SLLW;
                    {F7_NORMAL, F3_SRL_SRA}:  ctrl_o.instr_type = SRLW;
                    {F7_SUB_SRA, F3_SRL_SRA}: ctrl_o.instr_type = SRAW;
                    default: begin
                        ctrl_o.instr_type = ADDW;
                        ctrl_o.illegal    = (instr_i.funct3 != F3_ADD_SUB);
                    end
                endcase
            end
            OP_ALU, OP_ALU_W: begin
                ctrl_o.regfile_we = 1'b1;
                ctrl_o.op_32      = (instr_i.opcode == OP_ALU_W);
                if (instr_i.funct7 == F7_MUL_DIV) begin
                    // funct3[2] splits mul from div, funct3[0] marks unsigned div
                    ctrl_o.unit      = instr_i.funct3[2] ? UNIT_DIV : UNIT_MUL;
                    ctrl_o.signed_op = instr_i.funct3[2] && !instr_i.funct3[0];
                end
                case ({ctrl_o.op_32, instr_i.funct7, instr_i.funct3})
                    {1'b0, F7_NORMAL, F3_ADD_SUB}:   ctrl_o.instr_type = ADD;
                    {1'b0, F7_SUB_SRA, F3_ADD_SUB}:  ctrl_o.instr_type = SUB;
                    {1'b0, F7_NORMAL, F3_SLL}:       ctrl_o.instr_type = SLL;
                    {1'b0, F7_NORMAL, F3_SLT}:       ctrl_o.instr_type = SLT;
                    {1'b0, F7_NORMAL, F3_SLTU}:      ctrl_o.instr_type = SLTU;
                    {1'b0, F7_NORMAL, F3_XOR}:       ctrl_o.instr_type = XOR;
                    {1'b0, F7_NORMAL, F3_SRL_SRA}:   ctrl_o.instr_type = SRL;
                    {1'b0, F7_SUB_SRA, F3_SRL_SRA}:  ctrl_o.instr_type = SRA;
                    {1'b0, F7_NORMAL, F3_OR}:        ctrl_o.instr_type = OR;
                    {1'b0, F7_NORMAL, F3_AND}:       ctrl_o.instr_type = AND;
                    {1'b0, F7_MUL_DIV, F3_MUL}:      ctrl_o.instr_type = MUL;
                    {1'b0, F7_MUL_DIV, F3_MULH}:     ctrl_o.instr_type = MULH;
                    {1'b0, F7_MUL_DIV, F3_MULHSU}:   ctrl_o.instr_type = MULHSU;
                    {1'b0, F7_MUL_DIV, F3_MULHU}:    ctrl_o.instr_type = MULHU;
                    {1'b0, F7_MUL_DIV, F3_DIV}:      ctrl_o.instr_type = DIV;
                    {1'b0, F7_MUL_DIV, F3_DIVU}:     ctrl_o.instr_type = DIVU;
                    {1'b0, F7_MUL_DIV, F3_REM}:      ctrl_o.instr_type = REM;
                    {1'b0, F7_MUL_DIV, F3_REMU}:     ctrl_o.instr_type = REMU;
                    {1'b1, F7_NORMAL, F3_ADD_SUB}:   ctrl_o.instr_type = ADDW;
                    {1'b1, F7_SUB_SRA, F3_ADD_SUB}:  ctrl_o.instr_type = SUBW;
                    {1'b1, F7_NORMAL, F3_SLL}:       ctrl_o.instr_type = SLLW;
                    {1'b1, F7_NORMAL, F3_SRL_SRA}:   ctrl_o.instr_type = SRLW;
                    {1'b1, F7_SUB_SRA, F3_SRL_SRA}:  ctrl_o.instr_type = SRAW;
                    {1'b1, F7_MUL_DIV, F3_MUL}:      ctrl_o.instr_type = MULW;
                    {1'b1, F7_MUL_DIV, F3_DIV}:      ctrl_o.instr_type = DIVW;
                    {1'b1, F7_MUL_DIV, F3_DIVU}:     ctrl_o.instr_type = DIVUW;
                    {1'b1, F7_MUL_DIV, F3_REM}:      ctrl_o.instr_type = REMW;
                    {1'b1, F7_MUL_DIV, F3_REMU}:     ctrl_o.instr_type = REMUW;
                    default:                         ctrl_o.illegal = 1'b1;
                endcase
            end
            // not supported by this core
            OP_ATOMICS, OP_FENCE, OP_SYSTEM: begin
                ctrl_o.illegal = 1'b1;
            end
            default: begin
                ctrl_o.illegal = 1'b1;
            end
        endcase
    end

    // the execute stage picks the jump link result by unit
    branch_wb_sel: assert final (ctrl_o.unit != UNIT_BRANCH || ctrl_o.wb_sel == FROM_BRANCH)
        else $error("branch unit without FROM_BRANCH write-back");

endmodule

`default_nettype wire

// File: verilog/imm_gen.sv
//**************************************************************************
// combinational; unknown opcodes fall back to the I format
//**************************************************************************

`default_nettype none

`include "decode_settings.svh"

module imm_gen (
    input  wire riscv_isa_pkg::instr_fields_t instr_i,
    output riscv_isa_pkg::xlen_t              imm_o
);

    import riscv_isa_pkg::*;

    instr_t raw;

    assign raw = instr_i;

    always_comb begin
        case (instr_i.opcode)
            OP_LUI, OP_AUIPC: begin
                imm_o = {{(`XLEN-32){raw[31]}}, raw[31:12], 12'b0};
            end
            OP_JAL: begin
                imm_o = {{(`XLEN-20){raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            OP_BRANCH: begin
                imm_o = {{(`XLEN-12){raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            OP_STORE: begin
                imm_o = {{(`XLEN-12){raw[31]}}, raw[31:25], raw[11:7]};
            end
            // I format, shamt and funct7 bits left as they are
            default: begin
                imm_o = {{(`XLEN-12){raw[31]}}, raw[31:20]};
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/decode_pkg.sv
//**************************************************************************
// types produced by the decode stage; exception causes use the mcause codes
//**************************************************************************

`default_nettype none

package decode_pkg;

    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        MULW, DIVW, DIVUW, REMW, REMUW,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR
    } instr_type_e;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MEM,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    typedef enum logic [1:0] {
        FROM_ALU,
        FROM_MEM,
        FROM_BRANCH
    } wb_sel_e;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2
    } ex_cause_e;

    typedef struct packed {
        ex_cause_e            cause;
        riscv_isa_pkg::xlen_t origin;
        logic                 valid;
    } exception_t;

    typedef struct packed {
        instr_type_e            instr_type;
        unit_e                  unit;
        wb_sel_e                wb_sel;
        logic                   regfile_we;
        logic                   use_imm;
        logic                   use_pc;
        logic                   op_32;
        logic                   signed_op;
        mem_op_e                mem_op;
        riscv_isa_pkg::funct3_t funct3;
        logic                   illegal;
    } decode_ctrl_t;

    typedef struct packed {
        riscv_isa_pkg::xlen_t      pc;
        riscv_isa_pkg::reg_addr_t  rs1;
        riscv_isa_pkg::reg_addr_t  rs2;
        riscv_isa_pkg::reg_addr_t  rd;
        riscv_isa_pkg::xlen_t      imm;
        decode_ctrl_t              ctrl;
        exception_t                ex;
    } decoded_instr_t;

    typedef struct packed {
        logic                 valid;
        riscv_isa_pkg::xlen_t jump_addr;
    } jump_req_t;

endpackage

`default_nettype wire

// File: verilog/riscv_isa_pkg.sv
//**************************************************************************
// RV64IM encodings; atomics, fence and system opcodes are named but not decoded
//**************************************************************************

`default_nettype none

package riscv_isa_pkg;

`include "decode_settings.svh"

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`INSTR_W-1:0] instr_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_ALU_I   = 7'b0010011,
        OP_ALU     = 7'b0110011,
        OP_ALU_I_W = 7'b0011011,
        OP_ALU_W   = 7'b0111011,
        OP_ATOMICS = 7'b0101111,
        OP_FENCE   = 7'b0001111,
        OP_SYSTEM  = 7'b1110011
    } opcode_e;

    localparam funct7_t F7_NORMAL  = 7'b0000000;
    localparam funct7_t F7_SUB_SRA = 7'b0100000;
    localparam funct7_t F7_MUL_DIV = 7'b0000001;

    // alu codes, shared by the immediate and word forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 = MUL_DIV
    localparam funct3_t F3_MUL    = 3'b000;
    localparam funct3_t F3_MULH   = 3'b001;
    localparam funct3_t F3_MULHSU = 3'b010;
    localparam funct3_t F3_MULHU  = 3'b011;
    localparam funct3_t F3_DIV    = 3'b100;
    localparam funct3_t F3_DIVU   = 3'b101;
    localparam funct3_t F3_REM    = 3'b110;
    localparam funct3_t F3_REMU   = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LD  = 3'b011;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_LWU = 3'b110;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;
    localparam funct3_t F3_SD = 3'b011;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_JALR = 3'b000;

    // R-type view, other formats are cut from the same bits
    typedef struct packed {
        funct7_t   funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        funct3_t   funct3;
        reg_addr_t rd;
        opcode_e   opcode;
    } instr_fields_t;

endpackage

`default_nettype wire

// File: verilog/decode_settings.svh
//**************************************************************************
// widths shared by the decode packages and modules; RV64 only
//**************************************************************************

`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// data and address width
`define XLEN 64
`define INSTR_W 32
`define REG_ADDR_W 5

`endif
